// ==== vlog.f ====
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
testbench/ex_stage_assert.sv
testbench/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = ex_stage_tb
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "PASS: all tests" > /dev/null

clean:
	rm -rf obj_dir

// ==== testbench/ex_stage_tb.sv ====
// Table-driven testbench for the execute stage, built from vlog.f and run through the Makefile
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

  localparam int unsigned reset_cycles = 2;

  // One stimulus row and the responses expected in that cycle
  typedef struct packed {
    ex_pkg::alu_req_t                 alu;
    logic                             alu_en;
    logic [ex_pkg::xlen-1:0]          op_c;
    ex_pkg::mult_req_t                mult;
    logic                             csr_access;
    logic [ex_pkg::xlen-1:0]          csr_rdata;
    logic                             alu_we;
    logic [ex_pkg::reg_addr_w-1:0]    alu_waddr;
    logic                             we;
    logic [ex_pkg::reg_addr_w-1:0]    waddr;
    logic                             lsu_en;
    logic                             lsu_ready;
    logic [ex_pkg::xlen-1:0]          lsu_rdata;
    logic                             wb_ready;
    logic                             branch;
    // Expected
    logic                             chk_fw;
    logic [ex_pkg::xlen-1:0]          exp_fw;
    logic                             exp_br;
    logic                             exp_ready;
    logic                             exp_valid;
    logic                             exp_multi;
    logic                             exp_wb_we;
    logic [ex_pkg::reg_addr_w-1:0]    exp_wb_waddr;
  } row_t;

  logic                           clk;
  logic                           rst_n;
  ex_pkg::alu_req_t               alu_req;
  logic                           alu_en;
  logic [ex_pkg::xlen-1:0]        alu_operand_c;
  ex_pkg::mult_req_t              mult_req;
  logic                           csr_access;
  logic [ex_pkg::xlen-1:0]        csr_rdata;
  logic                           regfile_alu_we;
  logic [ex_pkg::reg_addr_w-1:0]  regfile_alu_waddr;
  logic                           regfile_we;
  logic [ex_pkg::reg_addr_w-1:0]  regfile_waddr;
  logic                           lsu_en;
  logic [ex_pkg::xlen-1:0]        lsu_rdata;
  logic                           lsu_ready_ex;
  logic                           branch_in_ex;
  logic                           wb_ready;
  ex_pkg::rf_wr_t                 regfile_alu_fw;
  ex_pkg::rf_wr_t                 regfile_wb;
  logic [ex_pkg::xlen-1:0]        jump_target;
  logic                           branch_decision;
  logic                           mult_multicycle;
  logic                           ex_ready;
  logic                           ex_valid;

  row_t rows_q[$];
  // Reference model state carried from row to row
  logic                           m_high;
  logic [ex_pkg::xlen-1:0]        m_hi;
  logic                           m_we;
  logic [ex_pkg::reg_addr_w-1:0]  m_waddr;
  int unsigned                    cycle_cnt = 0;
  int unsigned                    cycle_limit = 1000;

  ex_stage i_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .alu_operand_c_i     (alu_operand_c),
    .mult_req_i          (mult_req),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .branch_in_ex_i      (branch_in_ex),
    .wb_ready_i          (wb_ready),
    .regfile_alu_fw_o    (regfile_alu_fw),
    .regfile_wb_o        (regfile_wb),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  always #5 clk = ~clk;

  // Run length guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run went past %0d cycles without finishing the table", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Compare outcome for slt and branch opcodes, zero for the rest
  function automatic logic cmp_ref(input ex_pkg::alu_op_e op,
                                   input logic [ex_pkg::xlen-1:0] a,
                                   input logic [ex_pkg::xlen-1:0] b);
    case (op)
      ex_pkg::alu_slt, ex_pkg::alu_lt:   return $signed(a) < $signed(b);
      ex_pkg::alu_sltu, ex_pkg::alu_ltu: return a < b;
      ex_pkg::alu_ge:                    return $signed(a) >= $signed(b);
      ex_pkg::alu_geu:                   return a >= b;
      ex_pkg::alu_eq:                    return a == b;
      ex_pkg::alu_ne:                    return a != b;
      default:                           return 1'b0;
    endcase
  endfunction

  function automatic logic [ex_pkg::xlen-1:0] alu_ref(input ex_pkg::alu_op_e op,
                                                     input logic [ex_pkg::xlen-1:0] a,
                                                     input logic [ex_pkg::xlen-1:0] b);
    case (op)
      ex_pkg::alu_add: return a + b;
      ex_pkg::alu_sub: return a - b;
      ex_pkg::alu_and: return a & b;
      ex_pkg::alu_or:  return a | b;
      ex_pkg::alu_xor: return a ^ b;
      ex_pkg::alu_sll: return a << b[4:0];
      ex_pkg::alu_srl: return a >> b[4:0];
      ex_pkg::alu_sra: return $signed(a) >>> b[4:0];
      default:         return {{(ex_pkg::xlen-1){1'b0}}, cmp_ref(op, a, b)};
    endcase
  endfunction

  // Full product of the extended operands, wraps cleanly for every sign mode
  function automatic logic [2*ex_pkg::xlen-1:0] mult_ref(input ex_pkg::mult_req_t m);
    logic [2*ex_pkg::xlen-1:0] a_ext;
    logic [2*ex_pkg::xlen-1:0] b_ext;
    a_ext = {{ex_pkg::xlen{1'b0}}, m.operand_a};
    b_ext = {{ex_pkg::xlen{1'b0}}, m.operand_b};
    if (m.op == ex_pkg::mult_hi_ss || m.op == ex_pkg::mult_hi_su) begin
      a_ext[2*ex_pkg::xlen-1:ex_pkg::xlen] = {ex_pkg::xlen{m.operand_a[ex_pkg::xlen-1]}};
    end
    if (m.op == ex_pkg::mult_hi_ss) begin
      b_ext[2*ex_pkg::xlen-1:ex_pkg::xlen] = {ex_pkg::xlen{m.operand_b[ex_pkg::xlen-1]}};
    end
    return a_ext * b_ext;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] tmp;
    tmp = $urandom;
    return tmp[0];
  endfunction

  function automatic logic [ex_pkg::reg_addr_w-1:0] rand_addr();
    logic [31:0] tmp;
    tmp = $urandom;
    return tmp[ex_pkg::reg_addr_w-1:0];
  endfunction

  // Quiet cycle with the downstream stages ready
  function automatic row_t idle_row();
    row_t r;
    r = '0;
    r.lsu_ready = 1'b1;
    r.wb_ready  = 1'b1;
    r.op_c      = $urandom;
    r.lsu_rdata = $urandom;
    r.csr_rdata = $urandom;
    return r;
  endfunction

  // Fill in the expected values, then step the model by one clock edge
  task automatic push_row(input row_t r);
    logic                       hi_op;
    logic                       m_rdy;
    logic [2*ex_pkg::xlen-1:0]  prod;
    logic [ex_pkg::xlen-1:0]    fw;
    hi_op       = (r.mult.op != ex_pkg::mult_lo);
    m_rdy       = !(!m_high && r.mult.en && hi_op);
    prod        = mult_ref(r.mult);
    r.exp_ready = (m_rdy & r.lsu_ready & r.wb_ready) | r.branch;
    r.exp_valid = (r.alu_en | r.mult.en | r.csr_access | r.lsu_en)
                  & m_rdy & r.lsu_ready & r.wb_ready;
    r.exp_multi = m_high;
    fw = '0;
    if (r.alu_en) begin
      fw = alu_ref(r.alu.operator, r.alu.operand_a, r.alu.operand_b);
    end
    if (r.mult.en) begin
      fw = m_high ? m_hi : prod[ex_pkg::xlen-1:0];
    end
    if (r.csr_access) begin
      fw = r.csr_rdata;
    end
    // Forwarded data is meaningless while the multiplier stalls
    r.chk_fw       = m_rdy;
    r.exp_fw       = fw;
    r.exp_br       = cmp_ref(r.alu.operator, r.alu.operand_a, r.alu.operand_b);
    r.exp_wb_we    = m_we;
    r.exp_wb_waddr = m_waddr;
    if (r.exp_valid) begin
      m_we = r.we;
      if (r.we) begin
        m_waddr = r.waddr;
      end
    end else if (r.wb_ready) begin
      m_we = 1'b0;
    end
    if (!m_high && r.mult.en && hi_op) begin
      m_high = 1'b1;
      m_hi   = prod[2*ex_pkg::xlen-1:ex_pkg::xlen];
    end else if (m_high && r.exp_ready) begin
      m_high = 1'b0;
    end
    rows_q.push_back(r);
  endtask

  // Multiply op, held for its second cycle when it is a high op
  task automatic push_mult(input ex_pkg::mult_op_e op,
                           input logic [ex_pkg::xlen-1:0] a,
                           input logic [ex_pkg::xlen-1:0] b);
    row_t r;
    r                = idle_row();
    r.mult.en        = 1'b1;
    r.mult.op        = op;
    r.mult.operand_a = a;
    r.mult.operand_b = b;
    r.alu_we         = 1'b1;
    r.alu_waddr      = rand_addr();
    push_row(r);
    if (op != ex_pkg::mult_lo) begin
      r.lsu_rdata = $urandom;
      push_row(r);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    row_t                     r;
    logic [ex_pkg::xlen-1:0]  dir_a [3];
    logic [ex_pkg::xlen-1:0]  dir_b [3];
    // Sign boundary, equal operands, minus one against one
    dir_a[0] = 32'h8000_0000;
    dir_b[0] = 32'h0000_0021;
    dir_a[1] = 32'h1234_5678;
    dir_b[1] = 32'h1234_5678;
    dir_a[2] = 32'hffff_ffff;
    dir_b[2] = 32'h0000_0001;
    // Every ALU opcode, three directed and two random operand pairs
    for (int i = 0; i < 16; i++) begin
      for (int j = 0; j < 5; j++) begin
        r              = idle_row();
        r.alu_en       = 1'b1;
        r.alu.operator = ex_pkg::alu_op_e'(i[3:0]);
        if (j < 3) begin
          r.alu.operand_a = dir_a[j];
          r.alu.operand_b = dir_b[j];
        end else begin
          r.alu.operand_a = $urandom;
          r.alu.operand_b = $urandom;
        end
        r.alu_we    = rand_bit();
        r.alu_waddr = rand_addr();
        r.we        = rand_bit();
        r.waddr     = rand_addr();
        push_row(r);
      end
    end
    // Multiplier, low word then each high mode
    for (int k = 0; k < 3; k++) begin
      push_mult(ex_pkg::mult_lo, $urandom, $urandom);
    end
    for (int k = 1; k < 4; k++) begin
      push_mult(ex_pkg::mult_op_e'(k[1:0]), 32'h8000_0000, 32'hffff_ffff);
      push_mult(ex_pkg::mult_op_e'(k[1:0]), $urandom, $urandom);
    end
    // High op held in mult_high by a busy write-back stage
    r                = idle_row();
    r.mult.en        = 1'b1;
    r.mult.op        = ex_pkg::mult_hi_ss;
    r.mult.operand_a = $urandom;
    r.mult.operand_b = $urandom;
    push_row(r);
    r.wb_ready = 1'b0;
    push_row(r);
    r.wb_ready = 1'b1;
    push_row(r);
    // Source priority, csr first then mult
    r                = idle_row();
    r.alu_en         = 1'b1;
    r.alu.operator   = ex_pkg::alu_xor;
    r.alu.operand_a  = $urandom;
    r.alu.operand_b  = $urandom;
    r.mult.en        = 1'b1;
    r.mult.operand_a = $urandom;
    r.mult.operand_b = $urandom;
    r.csr_access     = 1'b1;
    r.alu_we         = 1'b1;
    push_row(r);
    r.csr_access = 1'b0;
    push_row(r);
    // Load write port, capture then hold then flush
    r        = idle_row();
    r.alu_en = 1'b1;
    r.we     = 1'b1;
    r.waddr  = 6'h2a;
    push_row(r);
    r          = idle_row();
    r.wb_ready = 1'b0;
    push_row(r);
    push_row(r);
    push_row(idle_row());
    push_row(idle_row());
    // Stalls from the LSU and write-back, then a branch releasing ready
    r           = idle_row();
    r.alu_en    = 1'b1;
    r.lsu_en    = 1'b1;
    r.lsu_ready = 1'b0;
    push_row(r);
    r.lsu_ready = 1'b1;
    r.wb_ready  = 1'b0;
    push_row(r);
    r.wb_ready  = 1'b1;
    r.lsu_ready = 1'b0;
    r.branch    = 1'b1;
    push_row(r);
    push_row(idle_row());
    push_row(idle_row());
  endtask

  ////////////////////////////////////////////////////////////
  // Drive and compare
  ////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t r);
    alu_req           = r.alu;
    alu_en            = r.alu_en;
    alu_operand_c     = r.op_c;
    mult_req          = r.mult;
    csr_access        = r.csr_access;
    csr_rdata         = r.csr_rdata;
    regfile_alu_we    = r.alu_we;
    regfile_alu_waddr = r.alu_waddr;
    regfile_we        = r.we;
    regfile_waddr     = r.waddr;
    lsu_en            = r.lsu_en;
    lsu_rdata         = r.lsu_rdata;
    lsu_ready_ex      = r.lsu_ready;
    branch_in_ex      = r.branch;
    wb_ready          = r.wb_ready;
  endtask

  task automatic check_val(input string what, input int idx,
                           input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: row %0d %s, got %h expected %h", $time, idx, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_row(input row_t r, input int idx);
    if (r.chk_fw) begin
      check_val("forwarded data", idx, regfile_alu_fw.wdata, r.exp_fw);
    end
    check_val("forwarded we", idx, 32'(regfile_alu_fw.we), 32'(r.alu_we));
    check_val("forwarded addr", idx, 32'(regfile_alu_fw.waddr), 32'(r.alu_waddr));
    check_val("branch decision", idx, 32'(branch_decision), 32'(r.exp_br));
    check_val("jump target", idx, jump_target, r.op_c);
    check_val("ex_ready", idx, 32'(ex_ready), 32'(r.exp_ready));
    check_val("ex_valid", idx, 32'(ex_valid), 32'(r.exp_valid));
    check_val("multicycle", idx, 32'(mult_multicycle), 32'(r.exp_multi));
    check_val("wb we", idx, 32'(regfile_wb.we), 32'(r.exp_wb_we));
    check_val("wb addr", idx, 32'(regfile_wb.waddr), 32'(r.exp_wb_waddr));
    check_val("wb data", idx, regfile_wb.wdata, r.lsu_rdata);
  endtask

  initial begin
    void'($urandom(32'h7c52_a630));
    clk     = 1'b0;
    rst_n   = 1'b0;
    apply_row(idle_row());
    m_high  = 1'b0;
    m_hi    = '0;
    m_we    = 1'b0;
    m_waddr = '0;
    build_table();
    cycle_limit = 3 * rows_q.size() + reset_cycles;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // One row per cycle, checked once the outputs have settled
    foreach (rows_q[i]) begin
      @(negedge clk);
      apply_row(rows_q[i]);
      #2;
      check_row(rows_q[i], i);
    end
    if (i_dut.i_assert.fail_cnt != 0) begin
      $display("%0d assertion failures were reported", i_dut.i_assert.fail_cnt);
      $display("FAIL: see errors above");
      $fatal(1, "assertion failures");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/ex_stage_assert.sv ====
// Concurrent checks on the execute stage handshake and reset, bound into every ex_stage instance
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assert (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  ex_valid_i,
  input  logic  ex_ready_i,
  input  logic  wb_ready_i,
  input  logic  branch_i,
  input  logic  rf_we_i,
  input  logic  wb_we_i,
  input  logic  multicycle_i
);

  // Failure count, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // Valid only moves into a free write-back stage, which then holds the load write
  a_valid_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |=> $past(wb_ready_i) && (wb_we_i == $past(rf_we_i)))
    else begin
      $error("accepted op not taken into the EX/WB register");
      fail_cnt++;
    end

  // EX/WB register comes out of reset empty
  a_reset_we: assert property (@(posedge clk) $rose(rst_n) |-> !wb_we_i)
    else begin
      $error("regfile_wb_o.we high right after reset release");
      fail_cnt++;
    end

  // First cycle of a high multiply stalls the stage
  a_mult_stall: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(multicycle_i) |-> $past(!ex_ready_i || branch_i))
    else begin
      $error("ex_ready_o high in the cycle that entered mult_high");
      fail_cnt++;
    end

endmodule

bind ex_stage ex_stage_assert i_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .ex_valid_i   (ex_valid_o),
  .ex_ready_i   (ex_ready_o),
  .wb_ready_i   (wb_ready_i),
  .branch_i     (branch_in_ex_i),
  .rf_we_i      (regfile_we_i),
  .wb_we_i      (regfile_wb_o.we),
  .multicycle_i (mult_multicycle_o)
);

`default_nettype wire

// ==== hdl/ex_stage.sv ====
// Execute stage top, joins ALU, multiplier and write-back logic and runs the stall handshake
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  // ALU request and jump target
  input  ex_pkg::alu_req_t               alu_req_i,
  input  logic                           alu_en_i,
  input  logic [ex_pkg::xlen-1:0]        alu_operand_c_i,
  // Multiplier request
  input  ex_pkg::mult_req_t              mult_req_i,
  // CSR read data
  input  logic                           csr_access_i,
  input  logic [ex_pkg::xlen-1:0]        csr_rdata_i,
  // Write targets from decode
  input  logic                           regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0]  regfile_alu_waddr_i,
  input  logic                           regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0]  regfile_waddr_i,
  // LSU
  input  logic                           lsu_en_i,
  input  logic [ex_pkg::xlen-1:0]        lsu_rdata_i,
  input  logic                           lsu_ready_ex_i,
  // Stall control
  input  logic                           branch_in_ex_i,
  input  logic                           wb_ready_i,
  // Register file ports
  output ex_pkg::rf_wr_t                 regfile_alu_fw_o,
  output ex_pkg::rf_wr_t                 regfile_wb_o,
  // To fetch
  output logic [ex_pkg::xlen-1:0]        jump_target_o,
  output logic                           branch_decision_o,
  output logic                           mult_multicycle_o,
  output logic                           ex_ready_o,
  output logic                           ex_valid_o
);

  logic [ex_pkg::xlen-1:0]  alu_result;
  logic                     alu_cmp_result;
  logic [ex_pkg::xlen-1:0]  mult_result;
  logic                     mult_ready;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu i_alu (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback i_wb (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .alu_result_i        (alu_result),
    .mult_en_i           (mult_req_i.en),
    .mult_result_i       (mult_result),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .ex_valid_i          (ex_valid_o),
    .wb_ready_i          (wb_ready_i),
    .fw_o                (regfile_alu_fw_o),
    .wb_o                (regfile_wb_o)
  );

  ////////////////////////////////////////////////////////////
  // Branch and handshake
  ////////////////////////////////////////////////////////////

  // Branch outcome goes straight to fetch
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  // Branches finish here, so they free the stage without WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;

  // Valid moves right, independent of ex_ready
  assign ex_valid_o = (alu_en_i | mult_req_i.en | csr_access_i | lsu_en_i)
                      & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

`default_nettype wire

// ==== hdl/ex_writeback.sv ====
// Forwarding write port mux and EX/WB pipeline register feeding the load write port
`timescale 1ns/1ps
`default_nettype none

module ex_writeback (
  input  logic                           clk,
  input  logic                           rst_n,
  // Result sources
  input  logic                           alu_en_i,
  input  logic [ex_pkg::xlen-1:0]        alu_result_i,
  input  logic                           mult_en_i,
  input  logic [ex_pkg::xlen-1:0]        mult_result_i,
  input  logic                           csr_access_i,
  input  logic [ex_pkg::xlen-1:0]        csr_rdata_i,
  // ALU port target from decode
  input  logic                           regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0]  regfile_alu_waddr_i,
  // Load port target, passed to write-back
  input  logic                           regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0]  regfile_waddr_i,
  input  logic [ex_pkg::xlen-1:0]        lsu_rdata_i,
  // Handshake
  input  logic                           ex_valid_i,
  input  logic                           wb_ready_i,
  output ex_pkg::rf_wr_t                 fw_o,
  output ex_pkg::rf_wr_t                 wb_o
);

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  always_comb begin
    fw_o.we    = regfile_alu_we_i;
    fw_o.waddr = regfile_alu_waddr_i;
    fw_o.wdata = '0;
    // Later assignments win, so csr has top priority
    if (alu_en_i) begin
      fw_o.wdata = alu_result_i;
    end
    if (mult_en_i) begin
      fw_o.wdata = mult_result_i;
    end
    if (csr_access_i) begin
      fw_o.wdata = csr_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  logic                           we_q;
  logic [ex_pkg::reg_addr_w-1:0]  waddr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (ex_valid_i) begin
      // Accepted op, wb_ready is implied by valid
      we_q <= regfile_we_i;
      if (regfile_we_i) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new while WB is free, flush the old write
      we_q <= 1'b0;
    end
  end

  // Load data arrives from the LSU in the write-back cycle
  assign wb_o.we    = we_q;
  assign wb_o.waddr = waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

`default_nettype wire

// ==== hdl/ex_mult.sv ====
// Integer multiplier, low word in one cycle and registered high word in two cycles
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
  input  logic                     clk,
  input  logic                     rst_n,
  input  ex_pkg::mult_req_t        req_i,
  input  logic                     ex_ready_i,
  output logic [ex_pkg::xlen-1:0]  result_o,
  output logic                     ready_o,
  output logic                     multicycle_o
);

  ////////////////////////////////////////////////////////////
  // Product
  ////////////////////////////////////////////////////////////

  logic                                sign_a;
  logic                                sign_b;
  logic signed [ex_pkg::xlen:0]        op_a_ext;
  logic signed [ex_pkg::xlen:0]        op_b_ext;
  logic signed [2*ex_pkg::xlen+1:0]    product;
  logic                                is_high;

  ex_pkg::mult_state_e                 state_q;
  ex_pkg::mult_state_e                 state_d;
  logic                                hi_load;
  logic [ex_pkg::xlen-1:0]             hi_q;

  // Operand a is signed for ss and su, operand b only for ss
  assign sign_a  = (req_i.op == ex_pkg::mult_hi_ss) | (req_i.op == ex_pkg::mult_hi_su);
  assign sign_b  = (req_i.op == ex_pkg::mult_hi_ss);
  assign is_high = (req_i.op != ex_pkg::mult_lo);

  assign op_a_ext = {sign_a & req_i.operand_a[ex_pkg::xlen-1], req_i.operand_a};
  assign op_b_ext = {sign_b & req_i.operand_b[ex_pkg::xlen-1], req_i.operand_b};

  // 33x33 signed multiply covers all sign modes, upper two bits unused
  assign product = op_a_ext * op_b_ext;

  ////////////////////////////////////////////////////////////
  // High word sequencing
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    hi_load = 1'b0;
    case (state_q)
      ex_pkg::mult_idle: begin
        // First cycle of a high op, capture the upper word
        if (req_i.en && is_high) begin
          state_d = ex_pkg::mult_high;
          hi_load = 1'b1;
        end
      end
      ex_pkg::mult_high: begin
        // Leave only once the stage accepts, else hold under back-pressure
        if (ex_ready_i) begin
          state_d = ex_pkg::mult_idle;
        end
      end
      default: state_d = ex_pkg::mult_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::mult_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper word register
  always_ff @(posedge clk) begin
    if (hi_load) begin
      hi_q <= product[2*ex_pkg::xlen-1:ex_pkg::xlen];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Not ready in the first cycle of a high op
  assign ready_o      = ~((state_q == ex_pkg::mult_idle) & req_i.en & is_high);
  assign multicycle_o = (state_q == ex_pkg::mult_high);

  // Registered high word in the second cycle, low word otherwise
  assign result_o = multicycle_o ? hi_q : product[ex_pkg::xlen-1:0];

endmodule

`default_nettype wire

// ==== hdl/ex_alu.sv ====
// Combinational ALU of the execute stage, gives the result and the branch compare bit
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_pkg::alu_req_t         req_i,
  output logic [ex_pkg::xlen-1:0]  result_o,
  output logic                     cmp_result_o
);

  ////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////

  logic [ex_pkg::xlen-1:0]  op_a;
  logic [ex_pkg::xlen-1:0]  op_b;
  logic [4:0]               shamt;
  // Signed compare selects sign extension of the subtractor inputs
  logic                     cmp_signed;
  logic [ex_pkg::xlen:0]    diff_a;
  logic [ex_pkg::xlen:0]    diff_b;
  logic [ex_pkg::xlen:0]    diff;
  logic                     is_lt;
  logic                     is_eq;
  logic                     is_cmp;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  // Shift amount from the low five bits of operand b
  assign shamt = op_b[4:0];

  always_comb begin
    case (req_i.operator)
      ex_pkg::alu_slt,
      ex_pkg::alu_lt,
      ex_pkg::alu_ge:   cmp_signed = 1'b1;
      default:          cmp_signed = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Shared subtractor
  ////////////////////////////////////////////////////////////

  // One extra bit so the MSB of the difference is the less-than flag
  assign diff_a = {cmp_signed & op_a[ex_pkg::xlen-1], op_a};
  assign diff_b = {cmp_signed & op_b[ex_pkg::xlen-1], op_b};
  assign diff   = diff_a - diff_b;

  assign is_lt  = diff[ex_pkg::xlen];
  assign is_eq  = (op_a == op_b);

  ////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////

  always_comb begin
    cmp_result_o = 1'b0;
    is_cmp       = 1'b1;
    case (req_i.operator)
      ex_pkg::alu_slt,
      ex_pkg::alu_sltu,
      ex_pkg::alu_lt,
      ex_pkg::alu_ltu:  cmp_result_o = is_lt;
      ex_pkg::alu_ge,
      ex_pkg::alu_geu:  cmp_result_o = ~is_lt;
      ex_pkg::alu_eq:   cmp_result_o = is_eq;
      ex_pkg::alu_ne:   cmp_result_o = ~is_eq;
      // Arithmetic ops leave the branch decision low
      default:          is_cmp       = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    if (is_cmp) begin
      // Compares return the flag zero extended
      result_o = {{(ex_pkg::xlen-1){1'b0}}, cmp_result_o};
    end else begin
      case (req_i.operator)
        ex_pkg::alu_add: result_o = op_a + op_b;
        // Low bits of the shared difference are the same in both modes
        ex_pkg::alu_sub: result_o = diff[ex_pkg::xlen-1:0];
        ex_pkg::alu_and: result_o = op_a & op_b;
        ex_pkg::alu_or:  result_o = op_a | op_b;
        ex_pkg::alu_xor: result_o = op_a ^ op_b;
        ex_pkg::alu_sll: result_o = op_a << shamt;
        ex_pkg::alu_srl: result_o = op_a >> shamt;
        // Arithmetic shift keeps the sign
        ex_pkg::alu_sra: result_o = $signed(op_a) >>> shamt;
        default:         result_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ex_pkg.sv ====
// Shared widths, opcode enums and request structs for the execute stage and its testbench
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Integer datapath width
  localparam int unsigned xlen = 32;
  // Register address covers integer and float register files
  localparam int unsigned reg_addr_w = 6;

  ////////////////////////////////////////////////////////////
  // Opcodes and states
  ////////////////////////////////////////////////////////////

  // ALU operations, compares come last
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

  // Multiplier operations, high ops take two cycles
  typedef enum logic [1:0] {
    mult_lo,
    mult_hi_ss,
    mult_hi_uu,
    mult_hi_su
  } mult_op_e;

  // Multiplier sequencing
  typedef enum logic {
    mult_idle,
    mult_high
  } mult_state_e;

  ////////////////////////////////////////////////////////////
  // Port bundles
  ////////////////////////////////////////////////////////////

  // ALU request from decode, 68 bits
  typedef struct packed {
    alu_op_e          operator;
    logic [xlen-1:0]  operand_a;
    logic [xlen-1:0]  operand_b;
  } alu_req_t;

  // Multiplier request from decode, 67 bits
  typedef struct packed {
    logic             en;
    mult_op_e         op;
    logic [xlen-1:0]  operand_a;
    logic [xlen-1:0]  operand_b;
  } mult_req_t;

  // Register file write, used on both forwarding and write-back ports
  typedef struct packed {
    logic                   we;
    logic [reg_addr_w-1:0]  waddr;
    logic [xlen-1:0]        wdata;
  } rf_wr_t;

endpackage

`default_nettype wire
